// ==== project.f ====
logic/rename_cfg_pkg.sv
logic/rename_msg_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/rename_checkpoint.sv
logic/rename_stage.sv
verif/clock_gen.sv
verif/rename_tb.sv

// ==== Makefile ====
SOURCES := project.f $(wildcard logic/*.sv verif/*.sv)

.PHONY: all lint clean

all: obj_dir/Vrename_tb
	./obj_dir/Vrename_tb

obj_dir/Vrename_tb: $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module rename_tb -f project.f

lint:
	verilator --lint-only -Wall --timing --top-module rename_tb -f project.f

clean:
	rm -rf obj_dir

// ==== verif/rename_tb.sv ====
`default_nettype none

module rename_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int num_arch = rename_cfg_pkg::num_arch_regs_default;
	localparam int num_phys = rename_cfg_pkg::num_phys_regs_default;
	localparam int clock_period = 100;
	localparam int reset_cycles = 3;
	localparam int directed_cycles = 60;
	localparam int random_cycles = 400;

	logic clock;
	logic reset;
	logic rename_valid;
	rename_msg_pkg::rename_req_t rename_req;
	logic retire_valid;
	rename_msg_pkg::retire_t retire;
	logic mispredict;
	logic rsp_valid;
	rename_msg_pkg::rename_rsp_t rename_rsp;
	rename_cfg_pkg::fl_count_t free_count;

	// reference model, free tags in FIFO order plus one branch snapshot
	rename_cfg_pkg::phys_reg_t fl_q[$];
	rename_cfg_pkg::phys_reg_t snap_fl[$];
	rename_cfg_pkg::phys_reg_t snap_map [num_arch];
	logic snap_valid;
	// registered model outputs, these are what the assertions sample
	rename_cfg_pkg::phys_reg_t m_map [num_arch];
	rename_cfg_pkg::phys_reg_t m_head;
	rename_cfg_pkg::fl_count_t m_count;
	logic exp_valid;
	rename_msg_pkg::rename_rsp_t exp_rsp;
	string test_name;
	logic [31:0] seed = 32'd54093;

	clock_gen #(.period(clock_period), .reset_cycles(reset_cycles)) u_clock_gen (
		.clock(clock),
		.reset(reset)
	);

	rename_stage #(.num_arch_regs(num_arch), .num_phys_regs(num_phys)) dut (.*);

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic rename_msg_pkg::rename_req_t make_req(input int dest, input int src1,
			input int src2, input logic has_dest, input logic is_branch);
		rename_msg_pkg::rename_req_t req;
		req.dest = rename_cfg_pkg::arch_reg_t'(dest);
		req.src1 = rename_cfg_pkg::arch_reg_t'(src1);
		req.src2 = rename_cfg_pkg::arch_reg_t'(src2);
		req.has_dest = has_dest;
		req.is_branch = is_branch;
		return req;
	endfunction

	// one clock cycle of stimulus
	task automatic drive_cycle(input logic rv, input rename_msg_pkg::rename_req_t req,
			input logic tv, input int ret_tag, input logic mp);
		@(posedge clock);
		rename_valid <= rv;
		rename_req <= req;
		retire_valid <= tv;
		retire.tag <= rename_cfg_pkg::phys_reg_t'(ret_tag);
		mispredict <= mp;
	endtask

	task automatic report_mismatch(input string field, input int expected, input int actual);
		$display("Mismatch %s %s: expected %0d actual %0d", test_name, field, expected, actual);
		$display("Done: errors found");
		$fatal(1, "rename check failed");
	endtask

	// model update, same rules as the stage: mispredict first, then pop, push, snapshot
	always @(posedge clock) begin
		logic accept;
		rename_cfg_pkg::phys_reg_t new_map [num_arch];
		new_map = m_map;
		if (reset) begin
			fl_q.delete();
			for (int i = num_arch; i < num_phys; i++) fl_q.push_back(i);
			for (int i = 0; i < num_arch; i++) new_map[i] = i;
			snap_valid = 1'b0;
		end else if (mispredict) begin
			if (snap_valid) begin
				fl_q = snap_fl;
				new_map = snap_map;
			end
			snap_valid = 1'b0;
		end else begin
			accept = rename_valid && (!rename_req.has_dest || fl_q.size() != 0);
			if (accept && rename_req.has_dest) new_map[rename_req.dest] = fl_q.pop_front();
			if (retire_valid && fl_q.size() < num_phys) fl_q.push_back(retire.tag);
			if (accept && rename_req.is_branch) begin
				// snapshot taken after the branch's own rename
				snap_fl = fl_q;
				snap_map = new_map;
				snap_valid = 1'b1;
			end else if (snap_valid && retire_valid && snap_fl.size() < num_phys) begin
				snap_fl.push_back(retire.tag);
			end
		end
		m_map <= new_map;
		m_count <= rename_cfg_pkg::fl_count_t'(fl_q.size());
		m_head <= (fl_q.size() != 0) ? fl_q[0] : '0;
	end

	assign exp_valid = rename_valid && !mispredict && (!rename_req.has_dest || m_count != '0);
	assign exp_rsp.src1_tag = m_map[rename_req.src1];
	assign exp_rsp.src2_tag = m_map[rename_req.src2];
	assign exp_rsp.dest_tag = rename_req.has_dest ? m_head : '0;
	assign exp_rsp.old_dest_tag = rename_req.has_dest ? m_map[rename_req.dest] : '0;

	assert property (@(posedge clock) disable iff (reset) rsp_valid == exp_valid)
		else report_mismatch("rsp_valid", $sampled(exp_valid), $sampled(rsp_valid));
	assert property (@(posedge clock) disable iff (reset) rename_rsp.src1_tag == exp_rsp.src1_tag)
		else report_mismatch("src1_tag", $sampled(exp_rsp.src1_tag), $sampled(rename_rsp.src1_tag));
	assert property (@(posedge clock) disable iff (reset) rename_rsp.src2_tag == exp_rsp.src2_tag)
		else report_mismatch("src2_tag", $sampled(exp_rsp.src2_tag), $sampled(rename_rsp.src2_tag));
	// dest fields only mean something on an accepted request
	assert property (@(posedge clock) disable iff (reset)
			exp_valid |-> rename_rsp.dest_tag == exp_rsp.dest_tag)
		else report_mismatch("dest_tag", $sampled(exp_rsp.dest_tag), $sampled(rename_rsp.dest_tag));
	assert property (@(posedge clock) disable iff (reset)
			exp_valid |-> rename_rsp.old_dest_tag == exp_rsp.old_dest_tag)
		else report_mismatch("old_dest_tag", $sampled(exp_rsp.old_dest_tag),
			$sampled(rename_rsp.old_dest_tag));
	assert property (@(posedge clock) disable iff (reset) free_count == m_count)
		else report_mismatch("free_count", $sampled(m_count), $sampled(free_count));

	initial begin
		logic [31:0] r;
		rename_valid = 1'b0;
		rename_req = '0;
		retire_valid = 1'b0;
		retire = '0;
		mispredict = 1'b0;
		test_name = "reset";
		do @(posedge clock); while (reset);
		// sources not yet written still read their own index
		test_name = "alloc_order";
		for (int i = 0; i < 4; i++) drive_cycle(1'b1, make_req(i, 7 - i, 7 - i, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		test_name = "rewrite";
		drive_cycle(1'b1, make_req(5, 5, 5, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		drive_cycle(1'b1, make_req(5, 5, 1, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		// two tags left, so the last two with a dest get dropped
		test_name = "exhaust";
		for (int i = 0; i < 4; i++) drive_cycle(1'b1, make_req(6, 6, 6, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		drive_cycle(1'b1, make_req(0, 6, 2, 1'b0, 1'b0), 1'b0, 0, 1'b0);
		drive_cycle(1'b1, make_req(6, 6, 6, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		test_name = "retire_order";
		for (int i = 0; i < 3; i++) drive_cycle(1'b0, '0, 1'b1, i, 1'b0);
		drive_cycle(1'b1, make_req(1, 1, 1, 1'b1, 1'b0), 1'b1, 3, 1'b0);
		for (int i = 0; i < 3; i++) drive_cycle(1'b1, make_req(i + 2, 1, 0, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		test_name = "branch_restore";
		for (int i = 0; i < 4; i++) drive_cycle(1'b0, '0, 1'b1, 8 + i, 1'b0);
		drive_cycle(1'b1, make_req(2, 2, 3, 1'b1, 1'b1), 1'b0, 0, 1'b0);
		drive_cycle(1'b1, make_req(3, 2, 3, 1'b1, 1'b0), 1'b1, 5, 1'b0);
		drive_cycle(1'b1, make_req(4, 3, 4, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		drive_cycle(1'b0, '0, 1'b1, 6, 1'b0);
		// rename and retire in the mispredict cycle must be ignored
		drive_cycle(1'b1, make_req(7, 0, 0, 1'b1, 1'b0), 1'b1, 7, 1'b1);
		drive_cycle(1'b1, make_req(3, 2, 3, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		for (int i = 0; i < 4; i++) drive_cycle(1'b1, make_req(4, 4, 3, 1'b1, 1'b0), 1'b0, 0, 1'b0);
		test_name = "random_mix";
		for (int n = 0; n < random_cycles; n++) begin
			r = lcg_next();
			drive_cycle(r[9:8] != 2'd0, make_req(r[12:10], r[15:13], r[18:16], r[20:19] != 2'd0,
				r[23:21] == 3'd0), r[24], r[28:25], r[31:29] == 3'd0);
		end
		drive_cycle(1'b0, '0, 1'b0, 0, 1'b0);
		drive_cycle(1'b0, '0, 1'b0, 0, 1'b0);
		$display("Done: no errors");
		$finish;
	end

	// watchdog sized from the test lengths plus some slack
	initial begin
		#((reset_cycles + directed_cycles + random_cycles + 100) * clock_period);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== verif/clock_gen.sv ====
`default_nettype none

module clock_gen #(
	parameter int period = 100,
	parameter int reset_cycles = 3
) (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ns;

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// reset is synchronous, so release it on an edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== logic/rename_stage.sv ====
`default_nettype none

module rename_stage #(
	parameter int num_arch_regs = rename_cfg_pkg::num_arch_regs_default,
	parameter int num_phys_regs = rename_cfg_pkg::num_phys_regs_default
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic rename_valid,
	input wire rename_msg_pkg::rename_req_t rename_req,
	input wire logic retire_valid,
	input wire rename_msg_pkg::retire_t retire,
	input wire logic mispredict,
	output logic rsp_valid,
	output rename_msg_pkg::rename_rsp_t rename_rsp,
	output rename_cfg_pkg::fl_count_t free_count
);

	rename_cfg_pkg::phys_reg_t head_tag;
	logic fl_empty;
	rename_msg_pkg::fl_state_t fl_next;
	rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] map_next;
	rename_cfg_pkg::phys_reg_t src1_tag;
	rename_cfg_pkg::phys_reg_t src2_tag;
	rename_cfg_pkg::phys_reg_t old_dest_tag;
	logic restore;
	rename_msg_pkg::fl_state_t restore_state;
	rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] restore_map;
	logic accept;
	logic pop;
	logic branch_capture;
	logic retire_push;

	// mispredict cycle drops renames and retires alike
	// no free tag drops only requests that need one
	assign accept = rename_valid && !mispredict && (!rename_req.has_dest || !fl_empty);
	assign pop = accept && rename_req.has_dest;
	assign branch_capture = accept && rename_req.is_branch;
	assign retire_push = retire_valid && !mispredict;

	free_list #(
		.num_arch_regs(num_arch_regs),
		.num_phys_regs(num_phys_regs)
	) u_free_list (
		.clock(clock),
		.reset(reset),
		.pop(pop),
		.push(retire_push),
		.push_tag(retire.tag),
		.restore(restore),
		.restore_state(restore_state),
		.head_tag(head_tag),
		.empty(fl_empty),
		.count(free_count),
		.fl_next(fl_next)
	);

	map_table #(
		.num_arch_regs(num_arch_regs),
		.num_phys_regs(num_phys_regs)
	) u_map_table (
		.clock(clock),
		.reset(reset),
		.src1(rename_req.src1),
		.src2(rename_req.src2),
		.dest(rename_req.dest),
		.write(pop),
		.new_tag(head_tag),
		.restore(restore),
		.restore_map(restore_map),
		.src1_tag(src1_tag),
		.src2_tag(src2_tag),
		.old_dest_tag(old_dest_tag),
		.map_next(map_next)
	);

	rename_checkpoint #(
		.num_arch_regs(num_arch_regs),
		.num_phys_regs(num_phys_regs)
	) u_checkpoint (
		.clock(clock),
		.reset(reset),
		.capture(branch_capture),
		.fl_next(fl_next),
		.map_next(map_next),
		.retire_push(retire_push),
		.retire_tag(retire.tag),
		.mispredict(mispredict),
		.restore(restore),
		.restore_state(restore_state),
		.restore_map(restore_map)
	);

	// response is combinational, same cycle as the request
	assign rsp_valid = accept;
	assign rename_rsp.src1_tag = src1_tag;
	assign rename_rsp.src2_tag = src2_tag;
	// no destination means no tag handed out and nothing to free later
	assign rename_rsp.dest_tag = rename_req.has_dest ? head_tag : '0;
	assign rename_rsp.old_dest_tag = rename_req.has_dest ? old_dest_tag : '0;

endmodule

`default_nettype wire

// ==== logic/rename_checkpoint.sv ====
`default_nettype none

module rename_checkpoint #(
	parameter int num_arch_regs = rename_cfg_pkg::num_arch_regs_default,
	parameter int num_phys_regs = rename_cfg_pkg::num_phys_regs_default
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic capture,
	input wire rename_msg_pkg::fl_state_t fl_next,
	input wire rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] map_next,
	input wire logic retire_push,
	input wire rename_cfg_pkg::phys_reg_t retire_tag,
	input wire logic mispredict,
	output logic restore,
	output rename_msg_pkg::fl_state_t restore_state,
	output rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] restore_map
);

	rename_msg_pkg::fl_state_t snap_fl;
	rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] snap_map;
	logic snap_valid;
	logic snap_full;

	assign snap_full = (snap_fl.count == rename_cfg_pkg::fl_count_t'(num_phys_regs));

	// only a held snapshot can be restored
	assign restore = mispredict && snap_valid;
	assign restore_state = snap_fl;
	assign restore_map = snap_map;

	// valid flag, a mispredict consumes the snapshot
	always_ff @(posedge clock) begin
		if (reset) begin
			snap_valid <= 1'b0;
		end else if (mispredict) begin
			snap_valid <= 1'b0;
		end else if (capture) begin
			// a later branch just overwrites the older one
			snap_valid <= 1'b1;
		end
	end

	// snapshot payload
	always_ff @(posedge clock) begin
		if (capture) begin
			// post-update images, so the branch's own rename is kept
			// and any retire in this cycle is already in fl_next
			snap_fl <= fl_next;
			snap_map <= map_next;
		end else if (snap_valid && retire_push && !snap_full) begin
			// tags freed after the branch must survive a restore
			snap_fl.tags[rename_cfg_pkg::phys_reg_t'(snap_fl.count)] <= retire_tag;
			snap_fl.count <= snap_fl.count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`default_nettype none

module map_table #(
	parameter int num_arch_regs = rename_cfg_pkg::num_arch_regs_default,
	parameter int num_phys_regs = rename_cfg_pkg::num_phys_regs_default
) (
	input wire logic clock,
	input wire logic reset,
	input wire rename_cfg_pkg::arch_reg_t src1,
	input wire rename_cfg_pkg::arch_reg_t src2,
	input wire rename_cfg_pkg::arch_reg_t dest,
	input wire logic write,
	input wire rename_cfg_pkg::phys_reg_t new_tag,
	input wire logic restore,
	input wire rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] restore_map,
	output rename_cfg_pkg::phys_reg_t src1_tag,
	output rename_cfg_pkg::phys_reg_t src2_tag,
	output rename_cfg_pkg::phys_reg_t old_dest_tag,
	output rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] map_next
);

	// speculative mapping, one tag per architectural register
	rename_cfg_pkg::phys_reg_t [num_arch_regs-1:0] map;

	// lookups see the registered map only, no bypass of this cycle's write
	assign src1_tag = map[src1];
	assign src2_tag = map[src2];
	// mapping that dest had before this rename
	assign old_dest_tag = map[dest];

	always_comb begin
		map_next = map;
		if (restore) begin
			map_next = restore_map;
		end else if (write) begin
			map_next[dest] = new_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity mapping out of reset
			for (int i = 0; i < num_arch_regs; i++) begin
				map[i] <= rename_cfg_pkg::phys_reg_t'(i);
			end
		end else begin
			map <= map_next;
		end
	end

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
`default_nettype none

module free_list #(
	parameter int num_arch_regs = rename_cfg_pkg::num_arch_regs_default,
	parameter int num_phys_regs = rename_cfg_pkg::num_phys_regs_default
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic pop,
	input wire logic push,
	input wire rename_cfg_pkg::phys_reg_t push_tag,
	input wire logic restore,
	input wire rename_msg_pkg::fl_state_t restore_state,
	output rename_cfg_pkg::phys_reg_t head_tag,
	output logic empty,
	output rename_cfg_pkg::fl_count_t count,
	output rename_msg_pkg::fl_state_t fl_next
);

	// what the list does this cycle
	typedef enum logic [2:0] {
		op_hold,
		op_pop,
		op_push,
		op_pop_push,
		op_restore
	} fl_op_e;

	rename_msg_pkg::fl_state_t state;
	fl_op_e op;
	logic full;

	// head is always entry zero
	assign head_tag = state.tags[0];
	assign empty = (state.count == '0);
	assign full = (state.count == rename_cfg_pkg::fl_count_t'(num_phys_regs));
	assign count = state.count;

	// restore wins over everything
	// a push into a full list is dropped unless a pop makes room
	always_comb begin
		if (restore) begin
			op = op_restore;
		end else if (pop && !empty && push) begin
			op = op_pop_push;
		end else if (pop && !empty) begin
			op = op_pop;
		end else if (push && !full) begin
			op = op_push;
		end else begin
			op = op_hold;
		end
	end

	// next state, shared by the registers and the checkpoint
	always_comb begin
		fl_next = state;
		case (op)
			op_restore: begin
				fl_next = restore_state;
			end
			op_pop, op_pop_push: begin
				// shift everything one place toward the head
				for (int i = 0; i < num_phys_regs - 1; i++) begin
					fl_next.tags[i] = state.tags[i+1];
				end
				if (op == op_pop_push) begin
					// tail moved down by one, so write at count - 1
					fl_next.tags[rename_cfg_pkg::phys_reg_t'(state.count - 1'b1)] = push_tag;
				end else begin
					fl_next.count = state.count - 1'b1;
				end
			end
			op_push: begin
				fl_next.tags[rename_cfg_pkg::phys_reg_t'(state.count)] = push_tag;
				fl_next.count = state.count + 1'b1;
			end
			default: begin
				fl_next = state;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// map table starts with arch reg i on tag i
			// so the free tags are the ones above num_arch_regs, ascending
			for (int i = 0; i < num_phys_regs; i++) begin
				if (i < num_phys_regs - num_arch_regs) begin
					state.tags[i] <= rename_cfg_pkg::phys_reg_t'(i + num_arch_regs);
				end else begin
					state.tags[i] <= '0;
				end
			end
			state.count <= rename_cfg_pkg::fl_count_t'(num_phys_regs - num_arch_regs);
		end else begin
			state <= fl_next;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rename_msg_pkg.sv ====
`default_nettype none

package rename_msg_pkg;

	// one rename request from decode
	typedef struct packed {
		rename_cfg_pkg::arch_reg_t dest;
		rename_cfg_pkg::arch_reg_t src1;
		rename_cfg_pkg::arch_reg_t src2;
		// low for stores, branches without link and the like
		logic has_dest;
		// request opens a speculation window
		logic is_branch;
	} rename_req_t;

	// renamed operands handed on to dispatch
	typedef struct packed {
		rename_cfg_pkg::phys_reg_t src1_tag;
		rename_cfg_pkg::phys_reg_t src2_tag;
		rename_cfg_pkg::phys_reg_t dest_tag;
		// previous mapping of dest, freed when this instruction retires
		rename_cfg_pkg::phys_reg_t old_dest_tag;
	} rename_rsp_t;

	// retire notice, carries the tag that goes back to the free list
	typedef struct packed {
		rename_cfg_pkg::phys_reg_t tag;
	} retire_t;

	// whole free list image, used for the checkpoint and its restore
	// tags[0] is the head, valid entries are tags[0] .. tags[count-1]
	typedef struct packed {
		rename_cfg_pkg::phys_reg_t [rename_cfg_pkg::num_phys_regs_default-1:0] tags;
		rename_cfg_pkg::fl_count_t count;
	} fl_state_t;

endpackage

`default_nettype wire

// ==== logic/rename_cfg_pkg.sv ====
`default_nettype none

package rename_cfg_pkg;

	// register file sizes, the top level builds its parameters from these
	localparam int num_arch_regs_default = 8;
	localparam int num_phys_regs_default = 16;

	// index widths follow the sizes
	localparam int arch_reg_bits = $clog2(num_arch_regs_default);
	localparam int phys_reg_bits = $clog2(num_phys_regs_default);

	// occupancy must reach num_phys_regs itself, hence one extra bit
	localparam int fl_count_bits = $clog2(num_phys_regs_default + 1);

	// architectural register index
	typedef logic [arch_reg_bits-1:0] arch_reg_t;

	// physical register tag
	typedef logic [phys_reg_bits-1:0] phys_reg_t;

	// free list occupancy, 0 up to num_phys_regs
	typedef logic [fl_count_bits-1:0] fl_count_t;

endpackage

`default_nettype wire
